// File: files.f
+incdir+tests
design/cpu_pkg.sv
design/rf.sv
design/ifp.sv
design/dec.sv
design/ip.sv
design/lsp.sv
design/cpu.sv
tests/cpu_tb.sv

// File: Makefile
TOP = cpu_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f files.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: tests/cpu_tb_prog.svh
`ifndef CPU_TB_PROG_SVH
`define CPU_TB_PROG_SVH

localparam int PROG_LEN   = 23;
localparam int NUM_STORES = 6;

// Program at PC 0 with one instruction word per entry
localparam logic [31:0] PROG [PROG_LEN] = '{
    32'h10000513,  // 00 addi x10, x0, 0x100
    32'h123450b7,  // 04 lui  x1, 0x12345
    32'h67808093,  // 08 addi x1, x1, 0x678
    32'h00153023,  // 0c sd   x1, 0(x10)
    32'hfff00113,  // 10 addi x2, x0, -1
    32'h000121b3,  // 14 slt  x3, x2, x0
    32'h40208233,  // 18 sub  x4, x1, x2
    32'h0ff24293,  // 1c xori x5, x4, 0xff
    32'h7f02f313,  // 20 andi x6, x5, 0x7f0
    32'h003303b3,  // 24 add  x7, x6, x3
    32'h00753423,  // 28 sd   x7, 8(x10)
    32'h0012f433,  // 2c and  x8, x5, x1
    32'h00346433,  // 30 or   x8, x8, x3
    32'h00318463,  // 34 beq  x3, x3, +8
    32'h00253823,  // 38 sd   x2, 16(x10) is jumped over
    32'h00319463,  // 3c bne  x3, x3, +8
    32'h00853823,  // 40 sd   x8, 16(x10)
    32'h008004ef,  // 44 jal  x9, +8
    32'h00253c23,  // 48 sd   x2, 24(x10) is jumped over
    32'h00953c23,  // 4c sd   x9, 24(x10)
    32'h001509a3,  // 50 sb   x1, 0x13(x10)
    32'h00452e23,  // 54 sw   x4, 0x1c(x10)
    32'h0000006f   // 58 jal  x0, 0
};

// Each row holds address, write data and byte mask
localparam logic [135:0] EXP_STORES [NUM_STORES] = '{
    {64'h0000_0000_0000_0100, 64'h0000_0000_1234_5678, 8'hff},
    {64'h0000_0000_0000_0108, 64'h0000_0000_0000_0681, 8'hff},
    {64'h0000_0000_0000_0110, 64'h0000_0000_1234_5601, 8'hff},
    {64'h0000_0000_0000_0118, 64'h0000_0000_0000_0048, 8'hff},
    {64'h0000_0000_0000_0110, 64'h7878_7878_7878_7878, 8'h08},
    {64'h0000_0000_0000_0118, 64'h1234_5679_1234_5679, 8'hf0}
};

string store_name [NUM_STORES] = '{
    "lui_addi_forward",
    "alu_chain",
    "beq_taken_bne_untaken",
    "jal_link",
    "sb_lane",
    "sw_lane"
};

`endif

// File: tests/cpu_tb.sv
module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    `include "cpu_tb_prog.svh"

    localparam int CLK_PERIOD = 40;

    logic            clk;
    logic            rst_n;
    cpu_pkg::xlen_t  im_req_addr;
    logic            im_req_valid;
    logic            im_req_ready;
    cpu_pkg::instr_t im_resp_rdata;
    logic            im_resp_valid;
    cpu_pkg::xlen_t  dm_req_addr;
    cpu_pkg::xlen_t  dm_req_wdata;
    cpu_pkg::wmask_t dm_req_wmask;
    logic            dm_req_valid;
    logic            dm_req_ready;

    int              seed;
    logic [31:0]     rnd;
    logic [1:0]      resp_cnt;
    cpu_pkg::xlen_t  pend_addr;

    cpu #(.RESET_PC(64'h0)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Past the end of the program the memory holds addi x0, x0, 0
    function automatic logic [31:0] fetch_word(input cpu_pkg::xlen_t addr);
        if (addr < 64'(PROG_LEN * 4))
            return PROG[addr[6:2]];
        return 32'h00000013;
    endfunction

    // Both memory models are stepped once per falling edge
    task automatic drive_memories();
        im_resp_valid = 1'b0;
        if (resp_cnt != 2'd0) begin
            resp_cnt = resp_cnt - 2'd1;
            if (resp_cnt == 2'd0) begin
                im_resp_valid = 1'b1;
                im_resp_rdata = fetch_word(pend_addr);
            end
        end
        rnd          = $random(seed);
        im_req_ready = rnd[0] | rnd[1];
        dm_req_ready = rnd[2] | rnd[3];
        // Request transfers at the next rising edge and is answered 1 to 3 cycles later
        if (im_req_valid && im_req_ready) begin
            pend_addr = im_req_addr;
            resp_cnt  = (rnd[5:4] == 2'b00) ? 2'd1 : rnd[5:4];
        end
    endtask

    initial begin
        seed          = 32'h1a04;
        rst_n         = 1'b0;
        im_req_ready  = 1'b0;
        im_resp_valid = 1'b0;
        im_resp_rdata = '0;
        dm_req_ready  = 1'b0;
        resp_cnt      = 2'd0;
        pend_addr     = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        forever begin
            drive_memories();
            @(negedge clk);
        end
    end

    task automatic wait_store();
        do
            @(posedge clk);
        while (!(dm_req_valid && dm_req_ready));
    endtask

    task automatic check_field(input string test, input string field,
                               input logic [63:0] expected, input logic [63:0] actual);
        assert (actual == expected) else begin
            $display("Error: %s %s expected %h actual %h", test, field, expected, actual);
            $display("** FAIL **");
            $fatal(1, "Store did not match the expected value");
        end
    endtask

    initial begin
        logic [135:0] expected;
        wait (rst_n);
        for (int i = 0; i < NUM_STORES; i++) begin
            wait_store();
            expected = EXP_STORES[i];
            check_field(store_name[i], "addr", expected[135:72], dm_req_addr);
            check_field(store_name[i], "wdata", expected[71:8], dm_req_wdata);
            check_field(store_name[i], "wmask", {56'b0, expected[7:0]}, 64'(dm_req_wmask));
        end
        // Nothing else may reach the data memory in the quiet tail
        repeat (20) begin
            @(posedge clk);
            assert (!(dm_req_valid && dm_req_ready)) else begin
                $display("Extra store to address %h after the last expected one", dm_req_addr);
                $display("** FAIL **");
                $fatal(1, "Unexpected store on the data memory port");
            end
        end
        $display("** PASS **");
        $finish;
    end

    // Watchdog allows 50 cycles for each table entry
    initial begin
        repeat ((PROG_LEN + NUM_STORES) * 50) @(posedge clk);
        $display("** FAIL **");
        $fatal(1, "Timeout while waiting for the expected stores");
    end

endmodule

// File: design/cpu.sv
module cpu #(
    parameter cpu_pkg::xlen_t RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    // Instruction memory
    output cpu_pkg::xlen_t  im_req_addr,
    output logic            im_req_valid,
    input  logic            im_req_ready,
    input  cpu_pkg::instr_t im_resp_rdata,
    input  logic            im_resp_valid,
    // Data memory, writes only
    output cpu_pkg::xlen_t  dm_req_addr,
    output cpu_pkg::xlen_t  dm_req_wdata,
    output cpu_pkg::wmask_t dm_req_wmask,
    output logic            dm_req_valid,
    input  logic            dm_req_ready
);
    // Fetch to decode
    cpu_pkg::xlen_t      dec_pc;
    cpu_pkg::instr_t     dec_instr;
    logic                dec_valid, stall;
    // Register file
    cpu_pkg::reg_idx_t   rs1, rs2, wdst;
    cpu_pkg::xlen_t      rs1_data, rs2_data, wdata;
    logic                wen;
    // Integer pipe issue
    logic                ip_valid, ip_wb_en;
    cpu_pkg::xlen_t      ip_pc, ip_operand1, ip_operand2, ip_br_offset;
    cpu_pkg::xlen_t      ip_rs1_val, ip_rs2_val;
    cpu_pkg::reg_idx_t   ip_dst;
    cpu_pkg::alu_op_t    ip_alu_op;
    cpu_pkg::br_type_t   ip_br_type;
    // Store pipe issue
    logic                st_valid, lsp_busy;
    cpu_pkg::xlen_t      st_base, st_offset, st_source;
    cpu_pkg::mem_width_t st_width;
    // Bypass and redirect
    cpu_pkg::reg_idx_t   fwd_dst;
    cpu_pkg::xlen_t      fwd_data, new_pc;
    logic                fwd_valid, pc_override, pipe_flush;

    // Only a taken branch or JAL flushes
    assign pipe_flush = pc_override;

    ifp #(.RESET_PC(RESET_PC)) i_ifp (.*, .pc_override(pipe_flush));

    dec i_dec (.*);

    rf i_rf (.*);

    ip i_ip (.*);

    lsp i_lsp (.*, .busy(lsp_busy));

endmodule

// File: design/lsp.sv
module lsp (
    input  logic                clk,
    input  logic                rst_n,
    // Store issue
    input  logic                st_valid,
    input  cpu_pkg::xlen_t      st_base,
    input  cpu_pkg::xlen_t      st_offset,
    input  cpu_pkg::xlen_t      st_source,
    input  cpu_pkg::mem_width_t st_width,
    output logic                busy,
    // Data memory
    output cpu_pkg::xlen_t      dm_req_addr,
    output cpu_pkg::xlen_t      dm_req_wdata,
    output cpu_pkg::wmask_t     dm_req_wmask,
    output logic                dm_req_valid,
    input  logic                dm_req_ready
);
    cpu_pkg::xlen_t  addr;
    cpu_pkg::xlen_t  lane_data;
    cpu_pkg::wmask_t lane_mask;
    logic            aligned;

    assign addr = st_base + st_offset;

    // Source replicated over every lane and the mask picks the bytes
    always_comb begin
        case (st_width)
            cpu_pkg::MW_BYTE: begin
                lane_data = {8{st_source[7:0]}};
                lane_mask = 8'h01 << addr[2:0];
                aligned   = 1'b1;
            end
            cpu_pkg::MW_WORD: begin
                lane_data = {2{st_source[31:0]}};
                lane_mask = 8'h0f << {addr[2], 2'b00};
                aligned   = (addr[1:0] == 2'b00);
            end
            default: begin
                lane_data = st_source;
                lane_mask = 8'hff;
                aligned   = (addr[2:0] == 3'b000);
            end
        endcase
    end

    // A store entering counts as busy too
    assign busy = st_valid || (dm_req_valid && !dm_req_ready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            dm_req_valid <= 1'b0;
        else if (st_valid)
            dm_req_valid <= 1'b1;
        else if (dm_req_ready)
            dm_req_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (st_valid) begin
            dm_req_addr  <= {addr[cpu_pkg::XLEN-1:3], 3'b000};
            dm_req_wdata <= lane_data;
            dm_req_wmask <= lane_mask;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) st_valid |-> aligned);

    // Decode must hold a store back while one is still pending
    assert property (@(posedge clk) disable iff (!rst_n)
        st_valid |-> !(dm_req_valid && !dm_req_ready));

endmodule

// File: design/ip.sv
module ip (
    input  logic              clk,
    input  logic              rst_n,
    // Issue from decode
    input  logic              ip_valid,
    input  cpu_pkg::xlen_t    ip_pc,
    input  cpu_pkg::reg_idx_t ip_dst,
    input  logic              ip_wb_en,
    input  cpu_pkg::alu_op_t  ip_alu_op,
    input  cpu_pkg::xlen_t    ip_operand1,
    input  cpu_pkg::xlen_t    ip_operand2,
    input  cpu_pkg::br_type_t ip_br_type,
    input  cpu_pkg::xlen_t    ip_br_offset,
    input  cpu_pkg::xlen_t    ip_rs1_val,
    input  cpu_pkg::xlen_t    ip_rs2_val,
    // Writeback
    output logic              wen,
    output cpu_pkg::reg_idx_t wdst,
    output cpu_pkg::xlen_t    wdata,
    // Bypass to decode
    output cpu_pkg::reg_idx_t fwd_dst,
    output cpu_pkg::xlen_t    fwd_data,
    output logic              fwd_valid,
    // Redirect
    output logic              pc_override,
    output cpu_pkg::xlen_t    new_pc
);
    cpu_pkg::xlen_t    alu_res;
    cpu_pkg::xlen_t    result;
    logic              taken;
    logic              res_valid;
    cpu_pkg::reg_idx_t res_dst;
    cpu_pkg::xlen_t    res_data;

    always_comb begin
        case (ip_alu_op)
            cpu_pkg::ALU_SUB:    alu_res = ip_operand1 - ip_operand2;
            cpu_pkg::ALU_AND:    alu_res = ip_operand1 & ip_operand2;
            cpu_pkg::ALU_OR:     alu_res = ip_operand1 | ip_operand2;
            cpu_pkg::ALU_XOR:    alu_res = ip_operand1 ^ ip_operand2;
            cpu_pkg::ALU_SLT:    alu_res = {{(cpu_pkg::XLEN-1){1'b0}},
                                            $signed(ip_operand1) < $signed(ip_operand2)};
            cpu_pkg::ALU_PASS_B: alu_res = ip_operand2;
            default:             alu_res = ip_operand1 + ip_operand2;
        endcase
    end

    // JAL links to the next instruction
    assign result = (ip_br_type == cpu_pkg::BR_JAL) ? ip_pc + 64'd4 : alu_res;

    always_comb begin
        case (ip_br_type)
            cpu_pkg::BR_BEQ: taken = (ip_rs1_val == ip_rs2_val);
            cpu_pkg::BR_BNE: taken = (ip_rs1_val != ip_rs2_val);
            cpu_pkg::BR_JAL: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    // Resolved in the issue cycle so the wrong path never issues
    assign pc_override = ip_valid && taken;
    assign new_pc      = ip_pc + ip_br_offset;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            res_valid <= 1'b0;
        else
            res_valid <= ip_valid && ip_wb_en;
    end

    always_ff @(posedge clk) begin
        if (ip_valid) begin
            res_dst  <= ip_dst;
            res_data <= result;
        end
    end

    assign wen       = res_valid;
    assign wdst      = res_dst;
    assign wdata     = res_data;
    assign fwd_valid = res_valid;
    assign fwd_dst   = res_dst;
    assign fwd_data  = res_data;

endmodule

// File: design/dec.sv
module dec (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::xlen_t      dec_pc,
    input  cpu_pkg::instr_t     dec_instr,
    input  logic                dec_valid,
    output logic                stall,
    input  logic                pipe_flush,
    // Register file read
    output cpu_pkg::reg_idx_t   rs1,
    output cpu_pkg::reg_idx_t   rs2,
    input  cpu_pkg::xlen_t      rs1_data,
    input  cpu_pkg::xlen_t      rs2_data,
    // Bypass from the execute result register
    input  cpu_pkg::reg_idx_t   fwd_dst,
    input  cpu_pkg::xlen_t      fwd_data,
    input  logic                fwd_valid,
    input  logic                lsp_busy,
    // Integer pipe issue
    output logic                ip_valid,
    output cpu_pkg::xlen_t      ip_pc,
    output cpu_pkg::reg_idx_t   ip_dst,
    output logic                ip_wb_en,
    output cpu_pkg::alu_op_t    ip_alu_op,
    output cpu_pkg::xlen_t      ip_operand1,
    output cpu_pkg::xlen_t      ip_operand2,
    output cpu_pkg::br_type_t   ip_br_type,
    output cpu_pkg::xlen_t      ip_br_offset,
    output cpu_pkg::xlen_t      ip_rs1_val,
    output cpu_pkg::xlen_t      ip_rs2_val,
    // Store pipe issue
    output logic                st_valid,
    output cpu_pkg::xlen_t      st_base,
    output cpu_pkg::xlen_t      st_offset,
    output cpu_pkg::xlen_t      st_source,
    output cpu_pkg::mem_width_t st_width
);
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic                funct7_ok;
    cpu_pkg::xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j, imm;
    logic                wb_en, b_imm, is_store;
    cpu_pkg::alu_op_t    alu_op;
    cpu_pkg::br_type_t   br_type;
    cpu_pkg::mem_width_t width;
    // Issue register contents that feed the output bypass
    cpu_pkg::reg_idx_t   q_rs1, q_rs2;
    cpu_pkg::xlen_t      q_r1, q_r2, q_imm;
    logic                q_b_imm;

    function automatic cpu_pkg::xlen_t fwd(input cpu_pkg::reg_idx_t idx,
                                           input cpu_pkg::xlen_t val);
        if (fwd_valid && idx != '0 && idx == fwd_dst)
            return fwd_data;
        return val;
    endfunction

    assign opcode    = dec_instr[6:0];
    assign funct3    = dec_instr[14:12];
    assign rs1       = dec_instr[19:15];
    assign rs2       = dec_instr[24:20];
    assign funct7_ok = (dec_instr[31:25] == 7'b0) ||
                       (dec_instr[31:25] == 7'b0100000 && funct3 == 3'b000);

    assign imm_i = {{52{dec_instr[31]}}, dec_instr[31:20]};
    assign imm_s = {{52{dec_instr[31]}}, dec_instr[31:25], dec_instr[11:7]};
    assign imm_b = {{51{dec_instr[31]}}, dec_instr[31], dec_instr[7],
                    dec_instr[30:25], dec_instr[11:8], 1'b0};
    assign imm_u = {{32{dec_instr[31]}}, dec_instr[31:12], 12'b0};
    assign imm_j = {{43{dec_instr[31]}}, dec_instr[31], dec_instr[19:12],
                    dec_instr[20], dec_instr[30:21], 1'b0};

    // Anything unrecognized falls through as a no-op on the integer pipe
    always_comb begin
        alu_op   = cpu_pkg::ALU_ADD;
        br_type  = cpu_pkg::BR_NONE;
        width    = cpu_pkg::MW_DOUBLE;
        wb_en    = 1'b0;
        b_imm    = 1'b1;
        is_store = 1'b0;
        imm      = imm_i;
        case (opcode)
            cpu_pkg::OP_LUI: begin
                alu_op = cpu_pkg::ALU_PASS_B;
                imm    = imm_u;
                wb_en  = 1'b1;
            end
            cpu_pkg::OP_IMM: begin
                wb_en = 1'b1;
                case (funct3)
                    3'b000:  alu_op = cpu_pkg::ALU_ADD;
                    3'b100:  alu_op = cpu_pkg::ALU_XOR;
                    3'b110:  alu_op = cpu_pkg::ALU_OR;
                    3'b111:  alu_op = cpu_pkg::ALU_AND;
                    default: wb_en = 1'b0;
                endcase
            end
            cpu_pkg::OP_REG: begin
                wb_en = funct7_ok;
                b_imm = 1'b0;
                case (funct3)
                    3'b000:  alu_op = dec_instr[30] ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
                    3'b010:  alu_op = cpu_pkg::ALU_SLT;
                    3'b100:  alu_op = cpu_pkg::ALU_XOR;
                    3'b110:  alu_op = cpu_pkg::ALU_OR;
                    3'b111:  alu_op = cpu_pkg::ALU_AND;
                    default: wb_en = 1'b0;
                endcase
            end
            cpu_pkg::OP_BRANCH: begin
                imm = imm_b;
                if (funct3 == 3'b000)
                    br_type = cpu_pkg::BR_BEQ;
                else if (funct3 == 3'b001)
                    br_type = cpu_pkg::BR_BNE;
            end
            cpu_pkg::OP_JAL: begin
                imm     = imm_j;
                br_type = cpu_pkg::BR_JAL;
                wb_en   = 1'b1;
            end
            cpu_pkg::OP_STORE: begin
                imm      = imm_s;
                is_store = (funct3 == 3'b000) || (funct3 == 3'b010) || (funct3 == 3'b011);
                if (funct3 == 3'b000)
                    width = cpu_pkg::MW_BYTE;
                else if (funct3 == 3'b010)
                    width = cpu_pkg::MW_WORD;
            end
            default: ;
        endcase
    end

    // Back-pressure from the store pipe
    assign stall = dec_valid && is_store && lsp_busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ip_valid <= 1'b0;
            st_valid <= 1'b0;
        end else begin
            ip_valid <= dec_valid && !pipe_flush && !is_store;
            st_valid <= dec_valid && !pipe_flush && !stall && is_store;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid && !stall) begin
            ip_pc      <= dec_pc;
            ip_dst     <= dec_instr[11:7];
            ip_wb_en   <= wb_en;
            ip_alu_op  <= alu_op;
            ip_br_type <= br_type;
            st_width   <= width;
            q_rs1      <= rs1;
            q_rs2      <= rs2;
            q_r1       <= fwd(rs1, rs1_data);
            q_r2       <= fwd(rs2, rs2_data);
            q_imm      <= imm;
            q_b_imm    <= b_imm;
        end
    end

    // Second bypass catches the instruction issued just before this one
    assign ip_rs1_val   = fwd(q_rs1, q_r1);
    assign ip_rs2_val   = fwd(q_rs2, q_r2);
    assign ip_operand1  = ip_rs1_val;
    assign ip_operand2  = q_b_imm ? q_imm : ip_rs2_val;
    assign ip_br_offset = q_imm;
    assign st_base      = ip_rs1_val;
    assign st_offset    = q_imm;
    assign st_source    = ip_rs2_val;

    assert property (@(posedge clk) disable iff (!rst_n) !(ip_valid && st_valid));

endmodule

// File: design/ifp.sv
module ifp #(
    parameter cpu_pkg::xlen_t RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    // Instruction memory
    output cpu_pkg::xlen_t  im_req_addr,
    output logic            im_req_valid,
    input  logic            im_req_ready,
    input  cpu_pkg::instr_t im_resp_rdata,
    input  logic            im_resp_valid,
    // Redirect from the integer pipe
    input  logic            pc_override,
    input  cpu_pkg::xlen_t  new_pc,
    // Decoder side
    input  logic            stall,
    output cpu_pkg::xlen_t  dec_pc,
    output cpu_pkg::instr_t dec_instr,
    output logic            dec_valid
);
    cpu_pkg::fetch_state_t state;
    cpu_pkg::xlen_t        next_pc;
    logic                  discard;
    logic                  resp_take;
    logic                  buf_free;

    assign im_req_valid = (state == cpu_pkg::FS_REQ);
    // Response is dropped if flushed now or earlier
    assign resp_take = (state == cpu_pkg::FS_WAIT) && im_resp_valid && !discard && !pc_override;
    // Only fetch when the buffer is sure to be empty at response time
    assign buf_free = !dec_valid || !stall || pc_override;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= cpu_pkg::FS_IDLE;
            next_pc   <= RESET_PC;
            discard   <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            if (pc_override)
                next_pc <= new_pc;
            else if (resp_take)
                next_pc <= im_req_addr + 64'd4;

            case (state)
                cpu_pkg::FS_IDLE: if (buf_free) state <= cpu_pkg::FS_REQ;
                cpu_pkg::FS_REQ:  if (im_req_ready) state <= cpu_pkg::FS_WAIT;
                cpu_pkg::FS_WAIT: if (im_resp_valid) state <= cpu_pkg::FS_IDLE;
                default:          state <= cpu_pkg::FS_IDLE;
            endcase

            // Flush with a request still pending or in flight
            if (state == cpu_pkg::FS_WAIT && im_resp_valid)
                discard <= 1'b0;
            else if (pc_override && state != cpu_pkg::FS_IDLE)
                discard <= 1'b1;

            if (pc_override)
                dec_valid <= 1'b0;
            else if (resp_take)
                dec_valid <= 1'b1;
            else if (!stall)
                dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == cpu_pkg::FS_IDLE && buf_free)
            im_req_addr <= pc_override ? new_pc : next_pc;
        if (resp_take) begin
            dec_pc    <= im_req_addr;
            dec_instr <= im_resp_rdata;
        end
    end

    // Memory must never answer without an accepted request
    assert property (@(posedge clk) disable iff (!rst_n)
        im_resp_valid |-> state != cpu_pkg::FS_IDLE);

endmodule

// File: design/rf.sv
module rf (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::reg_idx_t rs1,
    input  cpu_pkg::reg_idx_t rs2,
    output cpu_pkg::xlen_t    rs1_data,
    output cpu_pkg::xlen_t    rs2_data,
    input  logic              wen,
    input  cpu_pkg::reg_idx_t wdst,
    input  cpu_pkg::xlen_t    wdata
);
    cpu_pkg::xlen_t regs [32];

    // x0 is hardwired to zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wdst != '0) begin
            regs[wdst] <= wdata;
        end
    end

endmodule

// File: design/cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [7:0]      wmask_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        // Passes operand 2 through for LUI
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_JAL
    } br_type_t;

    // WORD is the 32-bit width of SW
    typedef enum logic [1:0] {
        MW_BYTE,
        MW_WORD,
        MW_DOUBLE
    } mem_width_t;

    typedef enum logic [1:0] {
        FS_IDLE,
        FS_REQ,
        FS_WAIT
    } fetch_state_t;

    // Major opcodes of the kept subset
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_STORE  = 7'b0100011;

endpackage
